// ==== exec_mem_top.f ====
+incdir+src
src/exec_pkg.sv
src/alu_unit.sv
src/dmem_access.sv
src/fetch_unit.sv
src/bus_arbiter.sv
src/exec_mem_top.sv
test/tb_exec_mem_top.sv

// ==== src/alu_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module alu_unit (
    input  logic              alu_src_i,
    input  exec_pkg::opcode_t opcode_i,
    input  exec_pkg::funct3_t funct3_i,
    input  exec_pkg::funct7_t funct7_i,
    input  exec_pkg::word_t   reg1_i,
    input  exec_pkg::word_t   reg2_i,
    input  exec_pkg::word_t   imm_i,
    output exec_pkg::word_t   result_o,
    output exec_pkg::word_t   ld_addr_o,
    output exec_pkg::word_t   st_addr_o,
    output logic              branch_o
);
    import exec_pkg::*;

    word_t  op2;
    word_t  sum;
    word_t  agen;
    shamt_t shamt;
    logic   sub_sel;

    assign op2     = alu_src_i ? imm_i : reg2_i;
    assign shamt   = op2[4:0];
    assign sub_sel = (opcode_i == `OP_REG) && (funct7_i == `F7_SUB);   // no subi in rv32i
    assign sum     = sub_sel ? (reg1_i - op2) : (reg1_i + op2);
    assign agen    = reg1_i + imm_i;   // load/store effective address

    always_comb begin
        result_o  = '0;
        ld_addr_o = '0;   // zero means no access
        st_addr_o = '0;
        branch_o  = 1'b0;
        case (opcode_i)
            `OP_REG, `OP_IMM: begin
                case (funct3_i)
                    `F3_ADD: result_o = sum;
                    `F3_XOR: result_o = reg1_i ^ op2;
                    `F3_OR:  result_o = reg1_i | op2;
                    `F3_AND: result_o = reg1_i & op2;
                    `F3_SLL: result_o = reg1_i << shamt;
                    `F3_SRL: result_o = reg1_i >> shamt;
                    default: result_o = '0;
                endcase
            end
            `OP_LOAD: begin
                ld_addr_o = agen;
                result_o  = agen;
            end
            `OP_STORE: begin
                st_addr_o = agen;
                result_o  = reg2_i;   // store data rides on result
            end
            `OP_BRANCH: begin
                case (funct3_i)
                    `F3_BEQ: branch_o = (reg1_i == reg2_i);
                    `F3_BNE: branch_o = (reg1_i != reg2_i);
                    `F3_BLT: branch_o = (reg1_i < reg2_i);
                    `F3_BGE: branch_o = (reg1_i >= reg2_i);
                    default: branch_o = 1'b0;
                endcase
            end
            `OP_JAL, `OP_JALR: branch_o = 1'b1;   // jumps always taken
            `OP_LUI: result_o = {imm_i[19:0], 12'b0};
            default: begin
                result_o = '0;
                branch_o = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== src/bus_arbiter.sv ====
`timescale 1ns/100ps
`default_nettype none

module bus_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            d_req_i,
    input  logic            d_we_i,
    input  exec_pkg::word_t d_addr_i,
    input  exec_pkg::word_t d_wdata_i,
    input  logic            f_req_i,
    input  exec_pkg::word_t f_addr_i,
    input  logic            mem_ack_i,
    output logic            d_ack_o,
    output logic            f_ack_o,
    output logic            mem_req_o,
    output logic            mem_we_o,
    output exec_pkg::word_t mem_addr_o,
    output exec_pkg::word_t mem_wdata_o
);
    import exec_pkg::*;

    arb_state_t state;
    arb_state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            ARB_IDLE: begin
                if (d_req_i) begin
                    state_nxt = ARB_DATA;   // data side has priority
                end else if (f_req_i) begin
                    state_nxt = ARB_FETCH;
                end
            end
            ARB_DATA, ARB_FETCH: begin
                if (mem_ack_i) begin
                    state_nxt = ARB_IDLE;
                end
            end
            default: state_nxt = ARB_IDLE;
        endcase
    end

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // bus driven from the grant alone
    always_comb begin
        mem_req_o   = 1'b0;
        mem_we_o    = 1'b0;
        mem_addr_o  = '0;
        mem_wdata_o = '0;
        case (state)
            ARB_DATA: begin
                mem_req_o   = 1'b1;
                mem_we_o    = d_we_i;
                mem_addr_o  = d_addr_i;
                mem_wdata_o = d_wdata_i;
            end
            ARB_FETCH: begin
                mem_req_o  = 1'b1;   // fetch is read only
                mem_addr_o = f_addr_i;
            end
            default: mem_req_o = 1'b0;
        endcase
    end

    assign d_ack_o = (state == ARB_DATA) && mem_ack_i;
    assign f_ack_o = (state == ARB_FETCH) && mem_ack_i;

    // an ack only reaches a master that still holds its request
    a_ack_owner: assert property (@(posedge clk) disable iff (rst)
        (!d_ack_o || d_req_i) && (!f_ack_o || f_req_i));

    // memory only answers a granted request
    a_ack_granted: assert property (@(posedge clk) disable iff (rst)
        mem_ack_i |-> (state != ARB_IDLE));

endmodule

`default_nettype wire

// ==== src/dmem_access.sv ====
`timescale 1ns/100ps
`default_nettype none

module dmem_access (
    input  logic            clk,
    input  logic            rst,
    input  exec_pkg::word_t ld_addr_i,
    input  exec_pkg::word_t st_addr_i,
    input  exec_pkg::word_t st_data_i,
    input  logic            ack_i,
    input  exec_pkg::word_t rdata_i,
    output logic            req_o,
    output logic            we_o,
    output exec_pkg::word_t addr_o,
    output exec_pkg::word_t wdata_o,
    output exec_pkg::word_t load_data_o,
    output logic            data_done_o
);

    logic busy;
    logic ld_sel;
    logic st_sel;
    logic launch;
    logic finish;

    assign ld_sel = (ld_addr_i != '0);
    assign st_sel = (st_addr_i != '0) && !ld_sel;   // load wins
    assign launch = !busy && (ld_sel || st_sel);
    assign finish = req_o && ack_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            req_o       <= 1'b0;
            we_o        <= 1'b0;
            busy        <= 1'b0;
            data_done_o <= 1'b0;
        end else begin
            data_done_o <= finish;
            if (finish) begin
                req_o <= 1'b0;
                we_o  <= 1'b0;
            end else if (launch) begin
                req_o <= 1'b1;
                we_o  <= st_sel;
                busy  <= 1'b1;
            end else if (data_done_o) begin
                busy <= 1'b0;   // free one edge after the ack
            end
        end
    end

    always_ff @(posedge clk) begin
        if (launch) begin
            addr_o  <= ld_sel ? ld_addr_i : st_addr_i;
            wdata_o <= st_data_i;
        end
        if (finish && !we_o) begin
            load_data_o <= rdata_i;
        end
    end

    a_ctrl_known: assert property (@(posedge clk) disable iff (rst)
        !$isunknown({req_o, we_o}));

    // request must not move until the bus accepts it
    a_addr_hold: assert property (@(posedge clk) disable iff (rst)
        req_o && !ack_i |=> $stable(addr_o));

endmodule

`default_nettype wire

// ==== src/exec_macros.svh ====
`ifndef EXEC_MACROS_SVH
`define EXEC_MACROS_SVH

`define WORD_W 32

// major opcodes
`define OP_REG    7'b0110011
`define OP_IMM    7'b0010011
`define OP_LOAD   7'b0000011
`define OP_STORE  7'b0100011
`define OP_BRANCH 7'b1100011
`define OP_JAL    7'b1101111
`define OP_JALR   7'b1100111
`define OP_LUI    7'b0110111

`define F7_SUB 7'b0100000

`define F3_ADD 3'b000
`define F3_SLL 3'b001
`define F3_XOR 3'b100
`define F3_SRL 3'b101
`define F3_OR  3'b110
`define F3_AND 3'b111
`define F3_BEQ 3'b000
`define F3_BNE 3'b001
`define F3_BLT 3'b100   // unsigned compare in this core
`define F3_BGE 3'b101

`endif

// ==== src/exec_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module exec_mem_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              alu_src_i,
    input  exec_pkg::opcode_t opcode_i,
    input  exec_pkg::funct3_t funct3_i,
    input  exec_pkg::funct7_t funct7_i,
    input  exec_pkg::word_t   reg1_i,
    input  exec_pkg::word_t   reg2_i,
    input  exec_pkg::word_t   imm_i,
    input  logic              fetch_i,
    input  exec_pkg::word_t   pc_i,
    input  logic              mem_ack_i,
    input  exec_pkg::word_t   mem_rdata_i,
    output exec_pkg::word_t   result_o,
    output logic              branch_o,
    output exec_pkg::word_t   load_data_o,
    output logic              data_done_o,
    output exec_pkg::word_t   instr_o,
    output logic              instr_valid_o,
    output logic              mem_req_o,
    output logic              mem_we_o,
    output exec_pkg::word_t   mem_addr_o,
    output exec_pkg::word_t   mem_wdata_o
);
    import exec_pkg::*;

    word_t ld_addr;
    word_t st_addr;
    word_t alu_result;
    logic  d_req;
    logic  d_we;
    word_t d_addr;
    word_t d_wdata;
    logic  d_ack;
    logic  f_req;
    word_t f_addr;
    logic  f_ack;

    assign result_o = alu_result;

    alu_unit u_alu (
        .alu_src_i (alu_src_i),
        .opcode_i  (opcode_i),
        .funct3_i  (funct3_i),
        .funct7_i  (funct7_i),
        .reg1_i    (reg1_i),
        .reg2_i    (reg2_i),
        .imm_i     (imm_i),
        .result_o  (alu_result),
        .ld_addr_o (ld_addr),
        .st_addr_o (st_addr),
        .branch_o  (branch_o)
    );

    dmem_access u_dmem (
        .clk         (clk),
        .rst         (rst),
        .ld_addr_i   (ld_addr),
        .st_addr_i   (st_addr),
        .st_data_i   (alu_result),   // reg2 on a store
        .ack_i       (d_ack),
        .rdata_i     (mem_rdata_i),
        .req_o       (d_req),
        .we_o        (d_we),
        .addr_o      (d_addr),
        .wdata_o     (d_wdata),
        .load_data_o (load_data_o),
        .data_done_o (data_done_o)
    );

    fetch_unit u_fetch (
        .clk           (clk),
        .rst           (rst),
        .fetch_i       (fetch_i),
        .pc_i          (pc_i),
        .ack_i         (f_ack),
        .rdata_i       (mem_rdata_i),
        .req_o         (f_req),
        .addr_o        (f_addr),
        .instr_o       (instr_o),
        .instr_valid_o (instr_valid_o)
    );

    bus_arbiter u_arb (
        .clk         (clk),
        .rst         (rst),
        .d_req_i     (d_req),
        .d_we_i      (d_we),
        .d_addr_i    (d_addr),
        .d_wdata_i   (d_wdata),
        .f_req_i     (f_req),
        .f_addr_i    (f_addr),
        .mem_ack_i   (mem_ack_i),
        .d_ack_o     (d_ack),
        .f_ack_o     (f_ack),
        .mem_req_o   (mem_req_o),
        .mem_we_o    (mem_we_o),
        .mem_addr_o  (mem_addr_o),
        .mem_wdata_o (mem_wdata_o)
    );

endmodule

`default_nettype wire

// ==== src/exec_pkg.sv ====
`default_nettype none

`include "exec_macros.svh"

package exec_pkg;

    typedef logic [`WORD_W-1:0] word_t;     // data and address word

    typedef logic [6:0] opcode_t;

    typedef logic [2:0] funct3_t;

    typedef logic [6:0] funct7_t;

    typedef logic [4:0] shamt_t;            // shift amount, low five bits

    // who owns the memory port
    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_DATA,
        ARB_FETCH
    } arb_state_t;

endpackage

`default_nettype wire

// ==== src/fetch_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

module fetch_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            fetch_i,
    input  exec_pkg::word_t pc_i,
    input  logic            ack_i,
    input  exec_pkg::word_t rdata_i,
    output logic            req_o,
    output exec_pkg::word_t addr_o,
    output exec_pkg::word_t instr_o,
    output logic            instr_valid_o
);

    logic start;
    logic finish;

    assign start  = fetch_i && !req_o;   // pulse while busy is dropped
    assign finish = req_o && ack_i;

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            req_o         <= 1'b0;
            instr_valid_o <= 1'b0;
        end else begin
            instr_valid_o <= finish;
            if (finish) begin
                req_o <= 1'b0;
            end else if (start) begin
                req_o <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            addr_o <= pc_i;
        end
        if (finish) begin
            instr_o <= rdata_i;
        end
    end

    a_req_drop: assert property (@(posedge clk) disable iff (rst)
        ack_i |-> req_o ##1 !req_o);

endmodule

`default_nettype wire

// ==== test/tb_exec_mem_top.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "exec_macros.svh"

module tb_exec_mem_top;
    import exec_pkg::*;

    localparam int    CLK_PERIOD = 40;
    localparam int    N_ALU      = 40;
    localparam int    N_BRANCH   = 30;
    localparam int    N_MEM      = 10;   // loads, then as many stores
    localparam int    NUM_TESTS  = N_ALU + N_BRANCH + 2 * N_MEM + 1;
    localparam word_t RD_MASK    = 32'hA5A5_5A5A;

    logic    clk = 1'b0;
    logic    rst;
    logic    alu_src_i;
    opcode_t opcode_i;
    funct3_t funct3_i;
    funct7_t funct7_i;
    word_t   reg1_i;
    word_t   reg2_i;
    word_t   imm_i;
    logic    fetch_i;
    word_t   pc_i;
    logic    mem_ack_i;
    word_t   mem_rdata_i;
    word_t   result_o;
    logic    branch_o;
    word_t   load_data_o;
    logic    data_done_o;
    word_t   instr_o;
    logic    instr_valid_o;
    logic    mem_req_o;
    logic    mem_we_o;
    word_t   mem_addr_o;
    word_t   mem_wdata_o;

    logic [31:0] stim_lfsr = 32'h3505_13e7;
    logic [31:0] mem_lfsr  = 32'h3505_13e7;
    word_t       log_addr[$];
    logic        log_we[$];
    word_t       log_wdata[$];
    word_t       stored[word_t];   // store address to data

    exec_mem_top dut0 (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // one lfsr step per bit taken
    task automatic draw(input int nbits, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < nbits; i++) begin
            stim_lfsr = lfsr_next(stim_lfsr);
            v = {v[30:0], stim_lfsr[0]};
        end
    endtask

    task automatic draw_address(output word_t base, output word_t off);
        draw(32, base);
        draw(32, off);
        if (base + off == '0)
            off = off + 32'd4;   // zero address means no access
    endtask

    function automatic word_t model_read(input word_t addr);
        return addr ^ RD_MASK;
    endfunction

    // expected {branch, result} from the decoded fields
    function automatic logic [32:0] expected_alu(input logic src, input opcode_t opc,
            input funct3_t f3, input funct7_t f7, input word_t r1, input word_t r2,
            input word_t imm);
        word_t b;
        word_t res;
        logic  br;
        b   = src ? imm : r2;
        res = '0;
        br  = 1'b0;
        case (opc)
            `OP_REG, `OP_IMM: begin
                case (f3)
                    `F3_ADD: res = (opc == `OP_REG && f7 == `F7_SUB) ? r1 - b : r1 + b;
                    `F3_XOR: res = r1 ^ b;
                    `F3_OR:  res = r1 | b;
                    `F3_AND: res = r1 & b;
                    `F3_SLL: res = r1 << b[4:0];
                    `F3_SRL: res = r1 >> b[4:0];
                    default: res = '0;
                endcase
            end
            `OP_LOAD:  res = r1 + imm;
            `OP_STORE: res = r2;
            `OP_LUI:   res = imm << 12;
            `OP_BRANCH: begin
                case (f3)
                    `F3_BEQ: br = (r1 == r2);
                    `F3_BNE: br = (r1 != r2);
                    `F3_BLT: br = (r1 < r2);
                    `F3_BGE: br = !(r1 < r2);
                    default: br = 1'b0;
                endcase
            end
            `OP_JAL, `OP_JALR: br = 1'b1;
            default: res = '0;
        endcase
        return {br, res};
    endfunction

    task automatic check_equal(input string name, input logic [31:0] want,
            input logic [31:0] got);
        if (got !== want) begin
            $display("** Error: %s expected %h actual %h", name, want, got);
            $display("Some tests failed");
            $fatal(1);
        end
    endtask

    task automatic apply_inputs(input logic src, input opcode_t opc, input funct3_t f3,
            input funct7_t f7, input word_t r1, input word_t r2, input word_t imm);
        @(posedge clk);
        alu_src_i <= src;
        opcode_i  <= opc;
        funct3_i  <= f3;
        funct7_i  <= f7;
        reg1_i    <= r1;
        reg2_i    <= r2;
        imm_i     <= imm;
    endtask

    task automatic clear_bus_log();
        log_addr.delete();
        log_we.delete();
        log_wdata.delete();
    endtask

    task automatic run_alu_case(input logic control);
        logic [31:0] sel;
        logic [31:0] f3;
        logic [31:0] coin;
        logic [31:0] src;
        word_t       r1;
        word_t       r2;
        word_t       imm;
        opcode_t     opc;
        funct7_t     f7;
        logic [32:0] want;
        draw(2, sel);
        draw(3, f3);
        draw(1, src);
        draw(2, coin);
        draw(32, r1);
        draw(32, r2);
        draw(32, imm);
        if (control) begin
            opc = (sel == 2) ? `OP_JAL : (sel == 3) ? `OP_JALR : `OP_BRANCH;
            if (coin[1:0] == 2'd0)
                r2 = r1;   // let equality show up
        end else begin
            opc = (sel == 2) ? `OP_IMM : (sel == 3) ? `OP_LUI : `OP_REG;
        end
        f7 = coin[0] ? `F7_SUB : 7'h0;
        apply_inputs(src[0], opc, f3[2:0], f7, r1, r2, imm);
        want = expected_alu(src[0], opc, f3[2:0], f7, r1, r2, imm);
        @(negedge clk);
        check_equal("result_o", want[31:0], result_o);
        check_equal("branch_o", want[32], branch_o);
    endtask

    task automatic run_data_access(input logic is_store);
        word_t       base;
        word_t       off;
        word_t       data;
        opcode_t     opc;
        logic [32:0] want;
        draw_address(base, off);
        draw(32, data);
        opc = is_store ? `OP_STORE : `OP_LOAD;
        clear_bus_log();
        apply_inputs(1'b1, opc, 3'b010, 7'h0, base, data, off);
        want = expected_alu(1'b1, opc, 3'b010, 7'h0, base, data, off);
        @(negedge clk);
        check_equal("result_o", want[31:0], result_o);
        do
            @(posedge clk);
        while (data_done_o !== 1'b1);
        opcode_i <= `OP_IMM;   // drop the address before the unit frees up
        check_equal("bus accesses", 1, log_addr.size());
        check_equal("mem_addr_o", base + off, log_addr[0]);
        check_equal("mem_we_o", is_store, log_we[0]);
        if (is_store) begin
            check_equal("mem_wdata_o", data, log_wdata[0]);
            check_equal("store recorded", 1, stored.exists(base + off));
            check_equal("stored data", data, stored[base + off]);
        end else begin
            check_equal("load_data_o", model_read(base + off), load_data_o);
        end
    endtask

    task automatic run_fetch_with_load();
        word_t base;
        word_t off;
        word_t pc;
        logic  got_data;
        logic  got_instr;
        draw_address(base, off);
        draw(30, pc);
        pc        = pc << 2;
        got_data  = 1'b0;
        got_instr = 1'b0;
        clear_bus_log();
        apply_inputs(1'b1, `OP_LOAD, 3'b010, 7'h0, base, '0, off);
        fetch_i <= 1'b1;
        pc_i    <= pc;
        @(posedge clk);
        fetch_i <= 1'b0;
        while (!(got_data && got_instr)) begin
            @(posedge clk);
            if (data_done_o) begin
                got_data = 1'b1;
                opcode_i <= `OP_IMM;
                check_equal("load_data_o", model_read(base + off), load_data_o);
            end
            if (instr_valid_o) begin
                got_instr = 1'b1;
                check_equal("instr_o", model_read(pc), instr_o);
            end
        end
        check_equal("bus accesses", 2, log_addr.size());
        check_equal("first mem_addr_o", base + off, log_addr[0]);
        check_equal("second mem_addr_o", pc, log_addr[1]);
        check_equal("first mem_we_o", 0, log_we[0]);
        check_equal("second mem_we_o", 0, log_we[1]);
    endtask

    // memory answers after 0 to 3 cycles with a one cycle ack
    initial begin : memory_model
        logic [1:0] delay;
        mem_ack_i   = 1'b0;
        mem_rdata_i = '0;
        forever begin
            @(posedge clk);
            if (mem_req_o) begin
                mem_lfsr = lfsr_next(mem_lfsr);
                delay[0] = mem_lfsr[0];
                mem_lfsr = lfsr_next(mem_lfsr);
                delay[1] = mem_lfsr[0];
                repeat (delay) @(posedge clk);
                mem_ack_i   <= 1'b1;
                mem_rdata_i <= model_read(mem_addr_o);
                log_addr.push_back(mem_addr_o);
                log_we.push_back(mem_we_o);
                log_wdata.push_back(mem_wdata_o);
                if (mem_we_o)
                    stored[mem_addr_o] = mem_wdata_o;
                @(posedge clk);
                mem_ack_i <= 1'b0;
            end
        end
    end

    initial begin : watchdog
        #(NUM_TESTS * 20 * CLK_PERIOD);
        $display("timeout: run did not complete within %0d cycles", NUM_TESTS * 20);
        $display("Some tests failed");
        $fatal(1);
    end

    initial begin
        rst       = 1'b1;
        alu_src_i = 1'b0;
        opcode_i  = `OP_IMM;
        funct3_i  = '0;
        funct7_i  = '0;
        reg1_i    = '0;
        reg2_i    = '0;
        imm_i     = '0;
        fetch_i   = 1'b0;
        pc_i      = '0;
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        repeat (4) begin   // bus stays quiet until the first request
            @(negedge clk);
            check_equal("mem_req_o", 0, mem_req_o);
            check_equal("data_done_o", 0, data_done_o);
            check_equal("instr_valid_o", 0, instr_valid_o);
        end
        repeat (N_ALU) run_alu_case(1'b0);
        repeat (N_BRANCH) run_alu_case(1'b1);
        repeat (N_MEM) run_data_access(1'b0);
        repeat (N_MEM) run_data_access(1'b1);
        run_fetch_with_load();
        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire
